// ==== verilog/imuldiv_pkg.sv ====
// shared widths, function codes and control state for the mul/div unit
// referenced by scoped names from every module of the design
package imuldiv_pkg;

  // ------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------
  // operand or half of a response
  typedef logic [31:0] data_t;
  // full response word {hi, lo}
  typedef logic [63:0] result_t;
  // iteration counter
  typedef logic [4:0]  count_t;

  // ------------------------------------------------------------
  // function codes, value 3 falls through to divu
  // ------------------------------------------------------------
  typedef logic [1:0] fn_t;

  localparam fn_t FN_MUL  = 2'd0;
  localparam fn_t FN_DIV  = 2'd1;
  localparam fn_t FN_DIVU = 2'd2;

  // calculation cycles per operation, one per operand bit
  localparam int ITERATIONS = 32;

  // state machine shared by both iterative units
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } ctrl_state_t;

endpackage

// ==== verilog/imuldiv_mul_dpath.sv ====
// iterative multiplier datapath, shift-add on the operand magnitudes
// product sign is captured at load and applied to the registered result
`timescale 1ns/1ps

module imuldiv_mul_dpath (
  input  logic                 clk,
  input  logic                 reset,
  input  imuldiv_pkg::data_t   req_msg_a,
  input  imuldiv_pkg::data_t   req_msg_b,
  input  logic                 a_en,
  input  logic                 a_mux_sel,
  input  logic                 b_en,
  input  logic                 b_mux_sel,
  input  logic                 result_en,
  input  logic                 result_mux_sel,
  input  logic                 add_mux_sel,
  input  logic                 cntr_mux_sel,
  output logic                 counter_is_zero,
  output logic                 b_lsb,
  output imuldiv_pkg::result_t resp_msg_result
);

  // multiplicand widens to 64 bits as it shifts left
  imuldiv_pkg::result_t a_reg;
  imuldiv_pkg::data_t   b_reg;
  imuldiv_pkg::result_t result_reg;
  imuldiv_pkg::count_t  counter_reg;
  logic                 sign_reg;

  imuldiv_pkg::data_t   a_mag;
  imuldiv_pkg::data_t   b_mag;
  imuldiv_pkg::result_t a_mux_out;
  imuldiv_pkg::data_t   b_mux_out;
  imuldiv_pkg::result_t add_mux_out;
  imuldiv_pkg::count_t  counter_next;

  // ------------------------------------------------------------
  // operand magnitudes and next values
  // ------------------------------------------------------------
  assign a_mag = req_msg_a[31] ? (~req_msg_a + 1'b1) : req_msg_a;
  assign b_mag = req_msg_b[31] ? (~req_msg_b + 1'b1) : req_msg_b;

  // sel 0 loads, sel 1 takes the shifted value
  assign a_mux_out = a_mux_sel ? {a_reg[62:0], 1'b0} : {32'b0, a_mag};
  assign b_mux_out = b_mux_sel ? {1'b0, b_reg[31:1]} : b_mag;

  // accumulate a only when the current multiplier bit is set
  assign add_mux_out = add_mux_sel ? (result_reg + a_reg) : result_reg;

  // counter decrements in calc, otherwise sits at the start value
  assign counter_next = cntr_mux_sel ? (counter_reg - 1'b1)
                                     : imuldiv_pkg::count_t'(imuldiv_pkg::ITERATIONS - 1);

  // status back to the ctrl
  assign counter_is_zero = (counter_reg == '0);
  assign b_lsb           = b_reg[0];

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= imuldiv_pkg::count_t'(imuldiv_pkg::ITERATIONS - 1);
    end else begin
      counter_reg <= counter_next;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
    // result starts from zero on load
    if (result_en) begin
      result_reg <= result_mux_sel ? add_mux_out : '0;
    end
    // product is negative when exactly one operand is
    if (a_en && !a_mux_sel) begin
      sign_reg <= req_msg_a[31] ^ req_msg_b[31];
    end
  end

  // sign fix-up on the way out
  assign resp_msg_result = sign_reg ? (~result_reg + 1'b1) : result_reg;

endmodule

// ==== verilog/imuldiv_mul_ctrl.sv ====
// multiplier control, an idle/calc/done FSM with valid/ready on both sides
// drives the enables and mux selects of the multiplier datapath
`timescale 1ns/1ps

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  input  logic b_lsb,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic result_en,
  output logic result_mux_sel,
  output logic add_mux_sel,
  output logic cntr_mux_sel
);

  imuldiv_pkg::ctrl_state_t state;
  imuldiv_pkg::ctrl_state_t state_next;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------------------------------------
  // state transitions
  // ------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::IDLE: if (req_go) state_next = imuldiv_pkg::CALC;
      // last iteration runs in the cycle where the counter reads zero
      imuldiv_pkg::CALC: if (counter_is_zero) state_next = imuldiv_pkg::DONE;
      imuldiv_pkg::DONE: if (resp_go) state_next = imuldiv_pkg::IDLE;
      default:           state_next = imuldiv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign req_rdy  = (state == imuldiv_pkg::IDLE);
  assign resp_val = (state == imuldiv_pkg::DONE);

  always_comb begin
    // hold everything by default, done just waits
    a_en           = 1'b0;
    a_mux_sel      = 1'b0;
    b_en           = 1'b0;
    b_mux_sel      = 1'b0;
    result_en      = 1'b0;
    result_mux_sel = 1'b0;
    add_mux_sel    = 1'b0;
    cntr_mux_sel   = 1'b0;
    case (state)
      imuldiv_pkg::IDLE: begin
        // load magnitudes and clear the result on acceptance
        a_en      = req_go;
        b_en      = req_go;
        result_en = req_go;
      end
      imuldiv_pkg::CALC: begin
        a_en           = 1'b1;
        a_mux_sel      = 1'b1;
        b_en           = 1'b1;
        b_mux_sel      = 1'b1;
        result_en      = 1'b1;
        result_mux_sel = 1'b1;
        add_mux_sel    = b_lsb;
        cntr_mux_sel   = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== verilog/imuldiv_div_dpath.sv ====
// restoring divider datapath, remainder/quotient pair in one shift register
// signs of quotient and remainder are captured at load for DIV only
`timescale 1ns/1ps

module imuldiv_div_dpath (
  input  logic                 clk,
  input  logic                 reset,
  input  imuldiv_pkg::data_t   req_msg_a,
  input  imuldiv_pkg::data_t   req_msg_b,
  input  logic                 div_signed,
  input  logic                 a_en,
  input  logic                 a_mux_sel,
  input  logic                 b_en,
  input  logic                 sub_mux_sel,
  input  logic                 cntr_mux_sel,
  output logic                 counter_is_zero,
  output logic                 diff_msb,
  output imuldiv_pkg::result_t resp_msg_result
);

  // upper half remainder, lower half quotient
  imuldiv_pkg::result_t rq_reg;
  imuldiv_pkg::data_t   b_reg;
  imuldiv_pkg::count_t  counter_reg;
  logic                 sign_q_reg;
  logic                 sign_r_reg;

  logic                 a_neg;
  logic                 b_neg;
  imuldiv_pkg::data_t   a_mag;
  imuldiv_pkg::data_t   b_mag;
  logic [32:0]          diff;
  imuldiv_pkg::result_t rq_shift;
  imuldiv_pkg::result_t rq_sub;
  imuldiv_pkg::result_t rq_mux_out;
  imuldiv_pkg::data_t   rem;
  imuldiv_pkg::data_t   quot;

  // ------------------------------------------------------------
  // load values, divu keeps the raw operands
  // ------------------------------------------------------------
  assign a_neg = div_signed & req_msg_a[31];
  assign b_neg = div_signed & req_msg_b[31];
  assign a_mag = a_neg ? (~req_msg_a + 1'b1) : req_msg_a;
  assign b_mag = b_neg ? (~req_msg_b + 1'b1) : req_msg_b;

  // ------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------
  // trial subtract on the shifted remainder, 33 bits wide so the
  // bit leaving the top of the register still counts
  assign diff     = rq_reg[63:31] - {1'b0, b_reg};
  assign diff_msb = diff[32];

  // plain shift keeps the old remainder, sub keeps the difference
  assign rq_shift = {rq_reg[62:0], 1'b0};
  assign rq_sub   = {diff[31:0], rq_reg[30:0], 1'b1};

  assign rq_mux_out = !a_mux_sel  ? {32'b0, a_mag} :
                      sub_mux_sel ? rq_sub         : rq_shift;

  assign counter_is_zero = (counter_reg == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= imuldiv_pkg::count_t'(imuldiv_pkg::ITERATIONS - 1);
    end else if (cntr_mux_sel) begin
      counter_reg <= counter_reg - 1'b1;
    end else begin
      counter_reg <= imuldiv_pkg::count_t'(imuldiv_pkg::ITERATIONS - 1);
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_reg <= rq_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mag;
    end
    // quotient negative on differing signs, remainder follows dividend
    if (a_en && !a_mux_sel) begin
      sign_q_reg <= a_neg ^ b_neg;
      sign_r_reg <= a_neg;
    end
  end

  // ------------------------------------------------------------
  // sign fix-up, response is {remainder, quotient}
  // ------------------------------------------------------------
  assign rem  = rq_reg[63:32];
  assign quot = rq_reg[31:0];

  assign resp_msg_result = {sign_r_reg ? (~rem + 1'b1) : rem,
                            sign_q_reg ? (~quot + 1'b1) : quot};

endmodule

// ==== verilog/imuldiv_div_ctrl.sv ====
// divider control, same idle/calc/done FSM shape as the multiplier
// keeps the trial difference whenever it is not negative
`timescale 1ns/1ps

module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  input  logic diff_msb,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic sub_mux_sel,
  output logic cntr_mux_sel
);

  imuldiv_pkg::ctrl_state_t state;
  imuldiv_pkg::ctrl_state_t state_next;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------------------------------------
  // state transitions
  // ------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::IDLE: if (req_go) state_next = imuldiv_pkg::CALC;
      imuldiv_pkg::CALC: if (counter_is_zero) state_next = imuldiv_pkg::DONE;
      // back-pressure holds here with the result frozen
      imuldiv_pkg::DONE: if (resp_go) state_next = imuldiv_pkg::IDLE;
      default:           state_next = imuldiv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign req_rdy  = (state == imuldiv_pkg::IDLE);
  assign resp_val = (state == imuldiv_pkg::DONE);

  always_comb begin
    a_en         = 1'b0;
    a_mux_sel    = 1'b0;
    b_en         = 1'b0;
    sub_mux_sel  = 1'b0;
    cntr_mux_sel = 1'b0;
    case (state)
      imuldiv_pkg::IDLE: begin
        // dividend and divisor load together
        a_en = req_go;
        b_en = req_go;
      end
      imuldiv_pkg::CALC: begin
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        sub_mux_sel  = !diff_msb;
        cntr_mux_sel = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== verilog/imuldiv_dispatch.sv ====
// routes each request to the multiplier or divider by function code
// tracks the busy unit so only one operation is in flight
`timescale 1ns/1ps

module imuldiv_dispatch (
  input  logic                 clk,
  input  logic                 reset,
  input  imuldiv_pkg::fn_t     req_msg_fn,
  input  logic                 req_val,
  output logic                 req_rdy,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output imuldiv_pkg::result_t resp_msg_result,
  output logic                 mul_req_val,
  input  logic                 mul_req_rdy,
  input  logic                 mul_resp_val,
  output logic                 mul_resp_rdy,
  input  imuldiv_pkg::result_t mul_resp_msg_result,
  output logic                 div_req_val,
  input  logic                 div_req_rdy,
  output logic                 div_signed,
  input  logic                 div_resp_val,
  output logic                 div_resp_rdy,
  input  imuldiv_pkg::result_t div_resp_msg_result
);

  // which unit owns the operation in flight
  typedef enum logic [1:0] {
    PEND_NONE,
    PEND_MUL,
    PEND_DIV
  } pend_t;

  pend_t pend;
  logic  idle;
  logic  is_mul;

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------
  assign idle   = (pend == PEND_NONE);
  assign is_mul = (req_msg_fn == imuldiv_pkg::FN_MUL);

  // valid is also gated so an idle unit cannot grab a request early
  assign mul_req_val = req_val && idle && is_mul;
  assign div_req_val = req_val && idle && !is_mul;
  // code 3 runs unsigned like divu
  assign div_signed  = (req_msg_fn == imuldiv_pkg::FN_DIV);

  assign req_rdy = idle && (is_mul ? mul_req_rdy : div_req_rdy);

  // ------------------------------------------------------------
  // response side, only the pending unit is visible
  // ------------------------------------------------------------
  assign mul_resp_rdy = resp_rdy && (pend == PEND_MUL);
  assign div_resp_rdy = resp_rdy && (pend == PEND_DIV);

  always_comb begin
    case (pend)
      PEND_MUL: begin
        resp_val        = mul_resp_val;
        resp_msg_result = mul_resp_msg_result;
      end
      PEND_DIV: begin
        resp_val        = div_resp_val;
        resp_msg_result = div_resp_msg_result;
      end
      default: begin
        resp_val        = 1'b0;
        resp_msg_result = div_resp_msg_result;
      end
    endcase
  end

  // set on the accepting edge, cleared when the response is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      pend <= PEND_NONE;
    end else if (req_val && req_rdy) begin
      pend <= is_mul ? PEND_MUL : PEND_DIV;
    end else if (resp_val && resp_rdy) begin
      pend <= PEND_NONE;
    end
  end

endmodule

// ==== verilog/imuldiv_top.sv ====
// top of the iterative multiply/divide unit
// dispatch in front of one multiplier and one divider dpath/ctrl pair
`timescale 1ns/1ps

module imuldiv_top (
  input  logic                 clk,
  input  logic                 reset,
  input  imuldiv_pkg::fn_t     req_msg_fn,
  input  imuldiv_pkg::data_t   req_msg_a,
  input  imuldiv_pkg::data_t   req_msg_b,
  input  logic                 req_val,
  output logic                 req_rdy,
  output imuldiv_pkg::result_t resp_msg_result,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  // ------------------------------------------------------------
  // dispatch to unit handshakes
  // ------------------------------------------------------------
  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;
  logic div_signed;

  imuldiv_pkg::result_t mul_resp_msg_result;
  imuldiv_pkg::result_t div_resp_msg_result;

  // multiplier ctrl/dpath wiring
  logic mul_a_en;
  logic mul_a_mux_sel;
  logic mul_b_en;
  logic mul_b_mux_sel;
  logic mul_result_en;
  logic mul_result_mux_sel;
  logic mul_add_mux_sel;
  logic mul_cntr_mux_sel;
  logic mul_counter_is_zero;
  logic mul_b_lsb;

  // divider ctrl/dpath wiring
  logic div_a_en;
  logic div_a_mux_sel;
  logic div_b_en;
  logic div_sub_mux_sel;
  logic div_cntr_mux_sel;
  logic div_counter_is_zero;
  logic div_diff_msb;

  imuldiv_dispatch dispatch (
    .clk                 (clk),
    .reset               (reset),
    .req_msg_fn          (req_msg_fn),
    .req_val             (req_val),
    .req_rdy             (req_rdy),
    .resp_val            (resp_val),
    .resp_rdy            (resp_rdy),
    .resp_msg_result     (resp_msg_result),
    .mul_req_val         (mul_req_val),
    .mul_req_rdy         (mul_req_rdy),
    .mul_resp_val        (mul_resp_val),
    .mul_resp_rdy        (mul_resp_rdy),
    .mul_resp_msg_result (mul_resp_msg_result),
    .div_req_val         (div_req_val),
    .div_req_rdy         (div_req_rdy),
    .div_signed          (div_signed),
    .div_resp_val        (div_resp_val),
    .div_resp_rdy        (div_resp_rdy),
    .div_resp_msg_result (div_resp_msg_result)
  );

  // ------------------------------------------------------------
  // multiplier, operands come straight from the top ports
  // ------------------------------------------------------------
  imuldiv_mul_dpath mul_dpath (
    .clk             (clk),
    .reset           (reset),
    .req_msg_a       (req_msg_a),
    .req_msg_b       (req_msg_b),
    .a_en            (mul_a_en),
    .a_mux_sel       (mul_a_mux_sel),
    .b_en            (mul_b_en),
    .b_mux_sel       (mul_b_mux_sel),
    .result_en       (mul_result_en),
    .result_mux_sel  (mul_result_mux_sel),
    .add_mux_sel     (mul_add_mux_sel),
    .cntr_mux_sel    (mul_cntr_mux_sel),
    .counter_is_zero (mul_counter_is_zero),
    .b_lsb           (mul_b_lsb),
    .resp_msg_result (mul_resp_msg_result)
  );

  imuldiv_mul_ctrl mul_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (mul_req_val),
    .req_rdy         (mul_req_rdy),
    .resp_val        (mul_resp_val),
    .resp_rdy        (mul_resp_rdy),
    .counter_is_zero (mul_counter_is_zero),
    .b_lsb           (mul_b_lsb),
    .a_en            (mul_a_en),
    .a_mux_sel       (mul_a_mux_sel),
    .b_en            (mul_b_en),
    .b_mux_sel       (mul_b_mux_sel),
    .result_en       (mul_result_en),
    .result_mux_sel  (mul_result_mux_sel),
    .add_mux_sel     (mul_add_mux_sel),
    .cntr_mux_sel    (mul_cntr_mux_sel)
  );

  // ------------------------------------------------------------
  // divider
  // ------------------------------------------------------------
  imuldiv_div_dpath div_dpath (
    .clk             (clk),
    .reset           (reset),
    .req_msg_a       (req_msg_a),
    .req_msg_b       (req_msg_b),
    .div_signed      (div_signed),
    .a_en            (div_a_en),
    .a_mux_sel       (div_a_mux_sel),
    .b_en            (div_b_en),
    .sub_mux_sel     (div_sub_mux_sel),
    .cntr_mux_sel    (div_cntr_mux_sel),
    .counter_is_zero (div_counter_is_zero),
    .diff_msb        (div_diff_msb),
    .resp_msg_result (div_resp_msg_result)
  );

  imuldiv_div_ctrl div_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (div_req_val),
    .req_rdy         (div_req_rdy),
    .resp_val        (div_resp_val),
    .resp_rdy        (div_resp_rdy),
    .counter_is_zero (div_counter_is_zero),
    .diff_msb        (div_diff_msb),
    .a_en            (div_a_en),
    .a_mux_sel       (div_a_mux_sel),
    .b_en            (div_b_en),
    .sub_mux_sel     (div_sub_mux_sel),
    .cntr_mux_sel    (div_cntr_mux_sel)
  );

endmodule

// ==== tb/imuldiv_tb.sv ====
// directed testbench for the iterative multiply/divide unit
// drives imuldiv_top over valid/ready and checks every response against a model
`timescale 1ns/1ps

module imuldiv_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY  = 2;
  localparam int SEED         = 88;
  // about 250 operations at about 40 cycles plus margin
  localparam int TIMEOUT      = 15000;
  // counted with the accepting edge as the first one
  localparam int LATENCY_EDGES = 33;
  localparam int RANDOM_OPS    = 200;

  logic                 clk;
  logic                 reset;
  imuldiv_pkg::fn_t     req_msg_fn;
  imuldiv_pkg::data_t   req_msg_a;
  imuldiv_pkg::data_t   req_msg_b;
  logic                 req_val;
  logic                 req_rdy;
  imuldiv_pkg::result_t resp_msg_result;
  logic                 resp_val;
  logic                 resp_rdy;

  int cycles;

  imuldiv_top uut (
    .clk             (clk),
    .reset           (reset),
    .req_msg_fn      (req_msg_fn),
    .req_msg_a       (req_msg_a),
    .req_msg_b       (req_msg_b),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_msg_result (resp_msg_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // run-length guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      fail_now($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT));
    end
  end

  // next drive point a little after the rising edge
  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // expected response built from the result rules with 64-bit math
  task automatic model(input imuldiv_pkg::fn_t fn, input imuldiv_pkg::data_t a,
                       input imuldiv_pkg::data_t b, output imuldiv_pkg::result_t expected);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        am;
    logic [63:0]        bm;
    logic [63:0]        qm;
    logic [63:0]        rm;
    logic               a_neg;
    logic               b_neg;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn == imuldiv_pkg::FN_MUL) begin
      expected = sa * sb;
    end else begin
      // divu and code 3 use the raw operands
      a_neg = (fn == imuldiv_pkg::FN_DIV) && a[31];
      b_neg = (fn == imuldiv_pkg::FN_DIV) && b[31];
      am    = a_neg ? -sa : {32'b0, a};
      bm    = b_neg ? -sb : {32'b0, b};
      if (bm == 64'd0) begin
        // divide by zero gives all ones and the dividend back
        qm = 64'h0000_0000_ffff_ffff;
        rm = am;
      end else begin
        qm = am / bm;
        rm = am % bm;
      end
      if (a_neg != b_neg) qm = -qm;
      // remainder follows the dividend sign
      if (a_neg) rm = -rm;
      expected = {rm[31:0], qm[31:0]};
    end
  endtask

  // one full operation with resp_rdy held low for stall cycles
  task automatic run_op(input imuldiv_pkg::fn_t fn, input imuldiv_pkg::data_t a,
                        input imuldiv_pkg::data_t b, input int stall);
    imuldiv_pkg::result_t expected;
    imuldiv_pkg::result_t held;
    int                   edges;
    model(fn, a, b, expected);
    req_msg_fn = fn;
    req_msg_a  = a;
    req_msg_b  = b;
    req_val    = 1'b1;
    #1;
    while (!req_rdy) begin
      tick();
    end
    // accepting edge
    tick();
    req_val = 1'b0;
    edges   = 1;
    while (!resp_val) begin
      assert (!req_rdy)
        else fail_now("req_rdy went high while an operation was in flight");
      tick();
      edges++;
    end
    assert (edges == LATENCY_EDGES)
      else fail_now($sformatf("MISMATCH at %0t: latency %0d edges, expected %0d",
                              $time, edges, LATENCY_EDGES));
    assert (resp_msg_result == expected)
      else fail_now($sformatf("MISMATCH at %0t: fn %0d a %h b %h got %h expected %h",
                              $time, fn, a, b, resp_msg_result, expected));
    held = resp_msg_result;
    // competing request during the stall must not be taken
    if (stall > 0) begin
      req_val = 1'b1;
    end
    repeat (stall) begin
      tick();
      assert (resp_val && !req_rdy)
        else fail_now("response dropped or request accepted under back-pressure");
      assert (resp_msg_result == held)
        else fail_now($sformatf("MISMATCH at %0t: result moved from %h to %h in a stall",
                                $time, held, resp_msg_result));
    end
    resp_rdy = 1'b1;
    tick();
    // response taken on that edge so the unit is idle in this cycle
    assert (!resp_val && req_rdy)
      else fail_now("unit not ready one cycle after the response was taken");
    resp_rdy = 1'b0;
    req_val  = 1'b0;
  endtask

  function automatic imuldiv_pkg::data_t rand_operand();
    int pick;
    pick = $urandom_range(0, 7);
    case (pick)
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;
      2: return 32'hffff_ffff;
      3: return $urandom_range(0, 15);
      default: return $urandom;
    endcase
  endfunction

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic reset_state();
    assert (req_rdy && !resp_val)
      else fail_now("after reset req_rdy is not high or resp_val is not low");
  endtask

  task automatic mul_directed();
    run_op(imuldiv_pkg::FN_MUL, 32'd0, 32'd0, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'd0, 32'd12345, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'd1, 32'd1, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'd7, 32'd6, 0);
    run_op(imuldiv_pkg::FN_MUL, -32'd3, 32'd9, 0);
    run_op(imuldiv_pkg::FN_MUL, -32'd4, -32'd5, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'h8000_0000, 32'h8000_0000, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'hffff_ffff, 32'd1, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff, 0);
    run_op(imuldiv_pkg::FN_MUL, 32'h8000_0000, 32'd1, 0);
  endtask

  task automatic div_directed();
    run_op(imuldiv_pkg::FN_DIV, 32'd20, 32'd3, 0);
    run_op(imuldiv_pkg::FN_DIV, -32'd20, 32'd3, 0);
    run_op(imuldiv_pkg::FN_DIV, 32'd20, -32'd3, 0);
    run_op(imuldiv_pkg::FN_DIV, -32'd20, -32'd3, 0);
    run_op(imuldiv_pkg::FN_DIV, 32'd7, 32'd0, 0);
    run_op(imuldiv_pkg::FN_DIV, -32'd7, 32'd0, 0);
    run_op(imuldiv_pkg::FN_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op(imuldiv_pkg::FN_DIV, 32'd0, 32'd5, 0);
    run_op(imuldiv_pkg::FN_DIVU, 32'd20, 32'd3, 0);
    run_op(imuldiv_pkg::FN_DIVU, 32'hffff_fff0, 32'd3, 0);
    run_op(imuldiv_pkg::FN_DIVU, 32'd5, 32'd0, 0);
    run_op(imuldiv_pkg::FN_DIVU, 32'h8000_0000, 32'hffff_ffff, 0);
    // code 3 behaves as divu
    run_op(2'd3, 32'd100, 32'd7, 0);
    run_op(2'd3, 32'hffff_ffff, 32'd2, 0);
  endtask

  // latency and req_rdy are checked inside every operation
  task automatic latency_directed();
    run_op(imuldiv_pkg::FN_MUL, 32'd3, 32'd5, 0);
    run_op(imuldiv_pkg::FN_DIV, 32'd100, 32'd9, 0);
    run_op(imuldiv_pkg::FN_DIVU, 32'd1, 32'd1, 0);
  endtask

  task automatic backpressure_directed();
    run_op(imuldiv_pkg::FN_MUL, 32'd11, -32'd13, $urandom_range(1, 10));
    run_op(imuldiv_pkg::FN_DIV, -32'd50, 32'd7, $urandom_range(1, 10));
    run_op(imuldiv_pkg::FN_DIVU, 32'hdead_beef, 32'd17, $urandom_range(1, 10));
    run_op(imuldiv_pkg::FN_MUL, 32'h8000_0000, -32'd1, $urandom_range(1, 10));
  endtask

  task automatic random_mix();
    imuldiv_pkg::fn_t   fn;
    imuldiv_pkg::data_t a;
    imuldiv_pkg::data_t b;
    int                 gap;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      fn  = imuldiv_pkg::fn_t'($urandom_range(0, 3));
      a   = rand_operand();
      b   = rand_operand();
      gap = $urandom_range(0, 3);
      repeat (gap) tick();
      run_op(fn, a, b, $urandom_range(0, 5));
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    cycles     = 0;
    clk        = 1'b0;
    reset      = 1'b1;
    req_msg_fn = imuldiv_pkg::FN_MUL;
    req_msg_a  = '0;
    req_msg_b  = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    reset_state();
    mul_directed();
    div_directed();
    latency_directed();
    backpressure_directed();
    random_mix();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== imuldiv_top.f ====
verilog/imuldiv_pkg.sv
verilog/imuldiv_mul_dpath.sv
verilog/imuldiv_mul_ctrl.sv
verilog/imuldiv_div_dpath.sv
verilog/imuldiv_div_ctrl.sv
verilog/imuldiv_dispatch.sv
verilog/imuldiv_top.sv
tb/imuldiv_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = imuldiv_tb
FILELIST = imuldiv_top.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero when the testbench stops on $fatal
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
